//--- source/raster_pkg.sv
package raster_pkg;

  // screen coordinate width in bits
  localparam int COORD_W = 16;

  // one whole-pixel screen coordinate
  // signed so that primitives may start off screen
  typedef logic signed [COORD_W-1:0] coord_t;

  // pixel position
  typedef struct packed
  {
    coord_t x; // column
    coord_t y; // row
  } point_s;

  // pair of corners
  // used for the clip window (p1 exclusive) and for the clipped span (p1 inclusive)
  typedef struct packed
  {
    point_s p0; // top-left corner
    point_s p1; // bottom-right corner
  } rect_s;

  // kind of drawing command
  typedef enum logic
  {
    OP_RECT = 1'b0, // filled axis-aligned rectangle
    OP_LINE = 1'b1  // bresenham line
  } op_e;

  // one drawing command as seen on the strobe
  // rect uses p0 inclusive and p1 exclusive
  // line uses both ends inclusive
  typedef struct packed
  {
    op_e    op; // primitive select
    point_s p0; // first corner or line start
    point_s p1; // second corner or line end
  } cmd_s;

endpackage

//--- source/rect_clipper.sv
module rect_clipper
  import raster_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  load_i,     // command accept strobe
  input  cmd_s  cmd_i,
  input  logic  clip_en_i,
  input  rect_s clip_win_i, // p1 exclusive
  output rect_s span_o,     // inclusive bounds
  output logic  empty_o     // nothing to draw
);

  // one guard bit so that p1 - 1 cannot wrap at the most negative coordinate
  typedef logic signed [COORD_W:0] ext_t;

  ext_t lo_x, lo_y; // lowest allowed corner
  ext_t hi_x, hi_y; // highest allowed corner
  ext_t x0, y0, x1, y1; // clamped inclusive bounds
  logic load_rect;

  function automatic ext_t ext_max(input ext_t a, input ext_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic ext_t ext_min(input ext_t a, input ext_t b);
    return (a < b) ? a : b;
  endfunction

  assign load_rect = load_i && (cmd_i.op == OP_RECT); // lines bypass the clipper

  always_comb
  begin
    if (clip_en_i)
    begin
      lo_x = ext_t'(clip_win_i.p0.x);
      lo_y = ext_t'(clip_win_i.p0.y);
      hi_x = ext_t'(clip_win_i.p1.x) - ext_t'(1); // window edge is exclusive too
      hi_y = ext_t'(clip_win_i.p1.y) - ext_t'(1);
    end
    else
    begin
      lo_x = '0; // keep to the positive quadrant
      lo_y = '0;
      hi_x = {1'b0, {COORD_W{1'b1}}}; // no upper limit
      hi_y = {1'b0, {COORD_W{1'b1}}};
    end
    x0 = ext_max(ext_t'(cmd_i.p0.x), lo_x);
    y0 = ext_max(ext_t'(cmd_i.p0.y), lo_y);
    x1 = ext_min(ext_t'(cmd_i.p1.x) - ext_t'(1), hi_x); // exclusive to inclusive
    y1 = ext_min(ext_t'(cmd_i.p1.y) - ext_t'(1), hi_y);
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      empty_o <= 1'b1;
    end
    else if (load_rect)
    begin
      empty_o <= (x0 > x1) || (y0 > y1); // covers inverted and fully clipped rects
    end
  end

  // bounds only matter when not empty so dropping the guard bit is safe
  always_ff @(posedge clk_i)
  begin
    if (load_rect)
    begin
      span_o.p0.x <= x0[COORD_W-1:0];
      span_o.p0.y <= y0[COORD_W-1:0];
      span_o.p1.x <= x1[COORD_W-1:0];
      span_o.p1.y <= y1[COORD_W-1:0];
    end
  end

endmodule

//--- source/span_counter.sv
module span_counter
  import raster_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   start_i, // jump to top-left corner
  input  logic   step_i,  // advance one pixel
  input  rect_s  span_i,  // inclusive bounds, held for the whole scan
  output point_s pos_o,
  output logic   last_o   // bottom-right corner reached
);

  point_s pos_q;
  logic   row_end; // at right edge of span
  logic   in_span; // position inside the inclusive bounds

  assign row_end = (pos_q.x == span_i.p1.x);
  assign last_o  = row_end && (pos_q.y == span_i.p1.y);
  assign pos_o   = pos_q;

  // row-major scan
  // x runs first and wraps back to the left edge at the end of each row
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pos_q <= '0;
    end
    else if (start_i)
    begin
      pos_q <= span_i.p0;
    end
    else if (step_i)
    begin
      if (row_end)
      begin
        pos_q.x <= span_i.p0.x; // back to left edge
        pos_q.y <= pos_q.y + coord_t'(1); // next row down
      end
      else
      begin
        pos_q.x <= pos_q.x + coord_t'(1);
      end
    end
  end

  assign in_span = (pos_q.x >= span_i.p0.x) && (pos_q.x <= span_i.p1.x) &&
                   (pos_q.y >= span_i.p0.y) && (pos_q.y <= span_i.p1.y);

  // the controller never steps past the last pixel
  // so every step must land inside the span
  a_step_in_span: assert property (
    @(posedge clk_i) disable iff (rst_i)
    step_i |=> in_span
  )
  else $error("span_counter stepped outside the span");

  // the span comes from the clipper and must not move while scanning
  a_span_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    step_i |-> $stable(span_i)
  )
  else $error("span changed during a scan");

endmodule

//--- source/bresenham_line.sv
module bresenham_line
  import raster_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   load_i,  // capture endpoints and set up deltas
  input  point_s p0_i,
  input  point_s p1_i,
  input  logic   start_i, // go to p0 and seed the error term
  input  logic   step_i,  // next pixel
  output point_s pos_o,
  output logic   last_o   // position is p1
);

  // deltas up to the full coordinate range need one extra bit when signed
  typedef logic signed [COORD_W:0] err_t;

  localparam coord_t ONE = coord_t'(1);

  point_s p0_q, p1_q; // registered endpoints
  point_s pos_q;
  err_t   dmaj_q, dmin_q; // absolute major and minor deltas
  err_t   err_q;
  logic   neg_x_q, neg_y_q; // walk direction per axis
  logic   x_major_q;
  err_t   dx, dy, adx, ady;
  err_t   err_dec; // error after the minor delta is taken off
  logic   minor_mv; // minor axis moves this step
  logic   mv_x, mv_y;
  coord_t inc_x, inc_y;

  // setup arithmetic on the incoming command
  assign dx  = err_t'(p1_i.x) - err_t'(p0_i.x);
  assign dy  = err_t'(p1_i.y) - err_t'(p0_i.y);
  assign adx = dx[COORD_W] ? -dx : dx;
  assign ady = dy[COORD_W] ? -dy : dy;

  always_ff @(posedge clk_i)
  begin
    if (load_i)
    begin
      p0_q      <= p0_i;
      p1_q      <= p1_i;
      neg_x_q   <= dx[COORD_W];
      neg_y_q   <= dy[COORD_W];
      x_major_q <= (adx >= ady); // ties walk along x
      dmaj_q    <= (adx >= ady) ? adx : ady;
      dmin_q    <= (adx >= ady) ? ady : adx;
    end
  end

  assign err_dec  = err_q - dmin_q;
  assign minor_mv = err_dec[COORD_W]; // went negative
  assign mv_x     = x_major_q || minor_mv;
  assign mv_y     = !x_major_q || minor_mv;
  assign inc_x    = neg_x_q ? -ONE : ONE;
  assign inc_y    = neg_y_q ? -ONE : ONE;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pos_q <= '0;
      err_q <= '0;
    end
    else if (start_i)
    begin
      pos_q <= p0_q;
      err_q <= dmaj_q >>> 1; // half the major delta
    end
    else if (step_i)
    begin
      if (mv_x)
      begin
        pos_q.x <= pos_q.x + inc_x;
      end
      if (mv_y)
      begin
        pos_q.y <= pos_q.y + inc_y;
      end
      err_q <= minor_mv ? err_dec + dmaj_q : err_dec; // add major delta back on a minor move
    end
  end

  assign pos_o  = pos_q;
  assign last_o = (pos_q == p1_q);

  // controller finishes on the last pixel instead of stepping past it
  a_no_step_at_end: assert property (
    @(posedge clk_i) disable iff (rst_i)
    step_i |-> !last_o
  )
  else $error("line stepped beyond its end point");

endmodule

//--- source/raster_ctrl.sv
module raster_ctrl
  import raster_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic cmd_valid_i,   // command strobe
  input  logic empty_i,       // nothing to draw for this command
  input  logic last_i,        // selected generator is on its final pixel
  input  logic pixel_ack_i,   // fragment stage took the pixel
  output logic load_o,        // capture the command
  output logic gen_start_o,   // load generator from its setup
  output logic gen_step_o,    // advance generator
  output logic pixel_valid_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [1:0]
  {
    IDLE   = 2'd0, // waiting for a strobe
    SETUP  = 2'd1, // clipper and stepper are registered, start the generator
    DRAW   = 2'd2, // pixel on the bus until acked
    FINISH = 2'd3  // one-cycle done pulse
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   xfer; // pixel handshake completes

  assign xfer = pixel_valid_o && pixel_ack_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (cmd_valid_i)
        begin
          state_d = SETUP;
        end
      end
      SETUP:
      begin
        state_d = empty_i ? FINISH : DRAW; // empty rect skips drawing
      end
      DRAW:
      begin
        if (xfer && last_i)
        begin
          state_d = FINISH;
        end
      end
      FINISH:
      begin
        state_d = IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign load_o        = (state_q == IDLE) && cmd_valid_i; // strobes while busy are dropped
  assign gen_start_o   = (state_q == SETUP);
  assign pixel_valid_o = (state_q == DRAW);
  assign gen_step_o    = xfer && !last_i; // no step after the final pixel
  assign busy_o        = (state_q != IDLE);
  assign done_o        = (state_q == FINISH);

  // held pixel is not withdrawn before the fragment stage takes it
  a_valid_held: assert property (
    @(posedge clk_i) disable iff (rst_i)
    pixel_valid_o && !pixel_ack_i |=> pixel_valid_o
  )
  else $error("pixel_valid_o dropped without ack");

endmodule

//--- source/gfx_raster_top.sv
module gfx_raster_top
  import raster_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   cmd_valid_i,
  input  cmd_s   cmd_i,
  input  logic   clip_en_i,
  input  rect_s  clip_win_i,
  output logic   busy_o,
  output logic   pixel_valid_o,
  output point_s pixel_o,
  input  logic   pixel_ack_i,
  output logic   done_o
);

  op_e    op_q; // op of the command being drawn
  logic   is_line;
  logic   load, gen_start, gen_step;
  logic   clip_empty, ctrl_empty;
  logic   last_sel;
  rect_s  span;
  point_s rect_pos, line_pos;
  logic   rect_last, line_last;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      op_q <= OP_RECT;
    end
    else if (load)
    begin
      op_q <= cmd_i.op;
    end
  end

  assign is_line    = (op_q == OP_LINE);
  assign ctrl_empty = clip_empty && !is_line; // a line always has at least p0
  assign last_sel   = is_line ? line_last : rect_last;
  assign pixel_o    = is_line ? line_pos : rect_pos;

  rect_clipper rect_clipper_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .load_i     (load),
    .cmd_i      (cmd_i),
    .clip_en_i  (clip_en_i),
    .clip_win_i (clip_win_i),
    .span_o     (span),
    .empty_o    (clip_empty)
  );

  span_counter span_counter_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (gen_start && !is_line), // steered by the stored op
    .step_i  (gen_step && !is_line),
    .span_i  (span),
    .pos_o   (rect_pos),
    .last_o  (rect_last)
  );

  bresenham_line bresenham_line_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .load_i  (load && (cmd_i.op == OP_LINE)),
    .p0_i    (cmd_i.p0),
    .p1_i    (cmd_i.p1),
    .start_i (gen_start && is_line),
    .step_i  (gen_step && is_line),
    .pos_o   (line_pos),
    .last_o  (line_last)
  );

  raster_ctrl raster_ctrl_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .empty_i       (ctrl_empty),
    .last_i        (last_sel),
    .pixel_ack_i   (pixel_ack_i),
    .load_o        (load),
    .gen_start_o   (gen_start),
    .gen_step_o    (gen_step),
    .pixel_valid_o (pixel_valid_o),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

endmodule

//--- dv/raster_tb.sv
module raster_tb
  import raster_pkg::*;
();

  logic   clk_i = 1'b0;
  logic   rst_i;
  logic   cmd_valid_i;
  cmd_s   cmd_i;
  logic   clip_en_i;
  rect_s  clip_win_i;
  logic   busy_o;
  logic   pixel_valid_o;
  point_s pixel_o;
  logic   pixel_ack_i;
  logic   done_o;

  point_s exp_q[$]; // pixels still owed by the DUT, in order
  int     error_count = 0;
  int     check_count = 0;
  logic   bp_en = 1'b0; // random back-pressure on ack
  logic   held_valid = 1'b0; // pixel stalled on the previous cycle
  logic   after_xfer = 1'b0; // a pixel transferred on the previous cycle
  point_s held_pix;
  point_s exp_pix;
  int     dx, dy;

  gfx_raster_top gfx_raster_top_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .clip_en_i     (clip_en_i),
    .clip_win_i    (clip_win_i),
    .busy_o        (busy_o),
    .pixel_valid_o (pixel_valid_o),
    .pixel_o       (pixel_o),
    .pixel_ack_i   (pixel_ack_i),
    .done_o        (done_o)
  );

  always
  begin
    #10 clk_i = ~clk_i;
  end

  // fragment stage acks three cycles in four when stalling
  always @(posedge clk_i)
  begin
    pixel_ack_i <= bp_en ? ($urandom_range(3) != 0) : 1'b1;
  end

  task automatic check_value(input int actual, input int expected, input string msg);
    check_count++;
    if (actual != expected)
    begin
      error_count++;
      $display("FAIL %0t: %s (got %0d, expected %0d)", $time, msg, actual, expected);
    end
  endtask

  function automatic void add_pixel(input int x, input int y);
    point_s p;
    p.x = coord_t'(x);
    p.y = coord_t'(y);
    exp_q.push_back(p);
  endfunction

  // ordered pixel list of one command, appended to exp_q
  function automatic void expected_pixels(input cmd_s cmd, input logic clip_en, input rect_s win);
    int x0, y0, x1, y1, x, y;
    int ddx, ddy, sx, sy, dmaj, dmin, err, guard;
    logic x_major;
    if (cmd.op == OP_RECT)
    begin
      x0 = cmd.p0.x;
      y0 = cmd.p0.y;
      x1 = cmd.p1.x - 1; // p1 exclusive
      y1 = cmd.p1.y - 1;
      if (clip_en)
      begin
        x0 = (x0 > win.p0.x) ? x0 : win.p0.x;
        y0 = (y0 > win.p0.y) ? y0 : win.p0.y;
        x1 = (x1 < win.p1.x - 1) ? x1 : win.p1.x - 1; // window p1 exclusive as well
        y1 = (y1 < win.p1.y - 1) ? y1 : win.p1.y - 1;
      end
      else
      begin
        x0 = (x0 < 0) ? 0 : x0; // clamp to zero only
        y0 = (y0 < 0) ? 0 : y0;
      end
      for (y = y0; y <= y1; y++)
      begin
        for (x = x0; x <= x1; x++)
        begin
          add_pixel(x, y);
        end
      end
    end
    else
    begin
      x = cmd.p0.x;
      y = cmd.p0.y;
      x1 = cmd.p1.x;
      y1 = cmd.p1.y;
      ddx = (x1 >= x) ? x1 - x : x - x1;
      ddy = (y1 >= y) ? y1 - y : y - y1;
      sx = (x1 >= x) ? 1 : -1;
      sy = (y1 >= y) ? 1 : -1;
      x_major = (ddx >= ddy); // ties go along x
      dmaj = x_major ? ddx : ddy;
      dmin = x_major ? ddy : ddx;
      err = dmaj / 2;
      guard = 0;
      add_pixel(x, y);
      while ((x != x1 || y != y1) && guard < 4096)
      begin
        err = err - dmin;
        if (err < 0)
        begin
          err = err + dmaj;
          if (x_major)
          begin
            y = y + sy;
          end
          else
          begin
            x = x + sx;
          end
        end
        if (x_major)
        begin
          x = x + sx;
        end
        else
        begin
          y = y + sy;
        end
        add_pixel(x, y);
        guard++;
      end
    end
  endfunction

  function automatic cmd_s make_cmd(input op_e op, input int x0, input int y0,
                                    input int x1, input int y1);
    cmd_s c;
    c.op = op;
    c.p0.x = coord_t'(x0);
    c.p0.y = coord_t'(y0);
    c.p1.x = coord_t'(x1);
    c.p1.y = coord_t'(y1);
    return c;
  endfunction

  function automatic rect_s make_window(input int x0, input int y0, input int x1, input int y1);
    rect_s r;
    r.p0.x = coord_t'(x0);
    r.p0.y = coord_t'(y0);
    r.p1.x = coord_t'(x1);
    r.p1.y = coord_t'(y1);
    return r;
  endfunction

  function automatic int rand_coord(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  // strobe one command, check the cycle-2 response and wait for done
  task automatic send_command(input cmd_s cmd, input logic clip_en, input rect_s win,
                              input logic poke_busy);
    int npix, limit, cycles;
    expected_pixels(cmd, clip_en, win);
    npix = exp_q.size();
    limit = 20 * npix + 50;
    @(posedge clk_i);
    cmd_i       <= cmd;
    clip_en_i   <= clip_en;
    clip_win_i  <= win;
    cmd_valid_i <= 1'b1;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    @(negedge clk_i); // setup cycle
    @(negedge clk_i); // first pixel or done
    check_value(int'(pixel_valid_o), (npix != 0) ? 1 : 0, "pixel_valid_o two cycles after strobe");
    check_value(int'(done_o), (npix == 0) ? 1 : 0, "done_o two cycles after strobe");
    check_value(int'(busy_o), 1, "busy_o two cycles after strobe");
    if (poke_busy)
    begin
      @(posedge clk_i);
      cmd_i       <= make_cmd(OP_LINE, 0, 0, 9, 9); // must never be drawn
      cmd_valid_i <= 1'b1;
      @(negedge clk_i);
      check_value(int'(busy_o), 1, "busy_o while second strobe is up");
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
      @(negedge clk_i);
    end
    cycles = 0;
    while (!done_o && cycles < limit)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done_o)
    begin
      error_count++;
      $display("timeout: done_o did not arrive within %0d cycles at time %0t", limit, $time);
      exp_q.delete();
    end
    else
    begin
      check_value(exp_q.size(), 0, "pixels still missing at done_o");
      @(negedge clk_i);
      check_value(int'(done_o), 0, "done_o longer than one cycle");
      check_value(int'(busy_o), 0, "busy_o high after done_o");
    end
  endtask

  task automatic draw_random(input op_e op, input logic clip_en);
    int x0, y0;
    rect_s win;
    x0 = rand_coord(-6, 14);
    y0 = rand_coord(-6, 14);
    win = make_window(rand_coord(0, 8), rand_coord(0, 8), rand_coord(4, 20), rand_coord(4, 20));
    if (op == OP_LINE)
    begin
      send_command(make_cmd(OP_LINE, x0, y0, rand_coord(-12, 20), rand_coord(-12, 20)),
                   clip_en, win, 1'b0);
    end
    else
    begin
      send_command(make_cmd(OP_RECT, x0, y0, x0 + rand_coord(-2, 10), y0 + rand_coord(-2, 10)),
                   clip_en, win, 1'b0);
    end
  endtask

  // monitor: held pixels stay put, transfers match the model in order
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (held_valid)
      begin
        check_value(int'(pixel_valid_o), 1, "pixel_valid_o dropped before ack");
        check_value(int'(pixel_o.x), int'(held_pix.x), "held pixel x changed");
        check_value(int'(pixel_o.y), int'(held_pix.y), "held pixel y changed");
      end
      // next pixel or done follows a transfer without a gap
      if (after_xfer)
      begin
        if (exp_q.size() == 0)
        begin
          check_value(int'(done_o), 1, "done_o in the cycle after the last pixel");
        end
        else
        begin
          check_value(int'(pixel_valid_o), 1, "next pixel in the cycle after a transfer");
        end
      end
      held_valid = pixel_valid_o && !pixel_ack_i;
      held_pix   = pixel_o;
      after_xfer = pixel_valid_o && pixel_ack_i;
      if (pixel_valid_o && pixel_ack_i)
      begin
        if (exp_q.size() == 0)
        begin
          error_count++;
          $display("unexpected pixel (%0d,%0d) at time %0t", pixel_o.x, pixel_o.y, $time);
        end
        else
        begin
          exp_pix = exp_q.pop_front();
          check_value(int'(pixel_o.x), int'(exp_pix.x), "pixel x");
          check_value(int'(pixel_o.y), int'(exp_pix.y), "pixel y");
        end
      end
    end
  end

  initial
  begin
    void'($urandom(32'hb7296961));
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    clip_en_i   = 1'b0;
    clip_win_i  = '0;
    pixel_ack_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    repeat (20) draw_random(OP_RECT, 1'b0); // unclipped, some corners negative
    repeat (20) draw_random(OP_RECT, 1'b1); // clipped against random windows

    // empty rects: zero width, inverted, clipped away, clamped away
    send_command(make_cmd(OP_RECT, 4, 4, 4, 9), 1'b0, clip_win_i, 1'b0);
    send_command(make_cmd(OP_RECT, 9, 9, 3, 3), 1'b0, clip_win_i, 1'b0);
    send_command(make_cmd(OP_RECT, 12, 2, 16, 6), 1'b1, make_window(0, 0, 10, 10), 1'b0);
    send_command(make_cmd(OP_RECT, -8, -8, -2, 3), 1'b0, clip_win_i, 1'b0);

    // lines around one centre: every octant, axes, diagonals and a single point
    for (dx = -6; dx <= 6; dx += 3)
    begin
      for (dy = -6; dy <= 6; dy += 3)
      begin
        send_command(make_cmd(OP_LINE, 2, -1, 2 + dx, -1 + dy), 1'b0, clip_win_i, 1'b0);
      end
    end
    repeat (20) draw_random(OP_LINE, 1'b0);

    bp_en = 1'b1;
    repeat (15) draw_random(OP_RECT, 1'b1);
    repeat (15) draw_random(OP_LINE, 1'b0);

    // second strobe while busy is dropped
    send_command(make_cmd(OP_RECT, 2, 2, 6, 4), 1'b0, clip_win_i, 1'b1);
    bp_en = 1'b0;
    send_command(make_cmd(OP_RECT, 2, 2, 6, 4), 1'b0, clip_win_i, 1'b1);
    repeat (5) @(negedge clk_i); // stray pixels would show up here

    $display("errors %0d, checks %0d", error_count, check_count);
    if (error_count == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/raster_pkg.sv
source/rect_clipper.sv
source/span_counter.sv
source/bresenham_line.sv
source/raster_ctrl.sv
source/gfx_raster_top.sv
dv/raster_tb.sv

//--- Makefile
# Verilator flow for the rasterizer testbench

VERILATOR ?= verilator
TOP       ?= raster_tb
RTL_TOP   ?= gfx_raster_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# status comes from the pass line in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Wall source/raster_pkg.sv source/rect_clipper.sv \
		source/span_counter.sv source/bresenham_line.sv source/raster_ctrl.sv \
		source/gfx_raster_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
